// File: logic/mipsPkg.sv
package mipsPkg;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opOri     = 6'b001101,
        opLw      = 6'b100011,
        opSw      = 6'b101011,
        opBeq     = 6'b000100,
        opLui     = 6'b001111,
        opJal     = 6'b000011
    } opcodeE;

    // function field for opSpecial, instr[5:0]
    typedef enum logic [5:0] {
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnJr   = 6'b001000
    } functE;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluLui  // b moved to upper half
    } aluOpE;

    typedef enum logic [1:0] {
        npcSeq,
        npcBranch,
        npcJump,
        npcReg
    } npcSelE;

    typedef enum logic [1:0] {
        wrRt,
        wrRd,
        wr31
    } wrSelE;

    typedef enum logic [1:0] {
        wdAlu,
        wdMem,
        wdPcPlus4
    } wdSelE;

    typedef enum logic {
        extZero,
        extSign
    } extSelE;

    localparam logic [4:0] linkReg = 5'd31;  // jal destination

endpackage

// File: logic/controller.sv
`timescale 1ns/100ps

module controller (
    input  logic [31:0]     instr,
    output mipsPkg::npcSelE npcSel,
    output mipsPkg::wrSelE  wrSel,
    output mipsPkg::wdSelE  wdSel,
    output logic            regWe,
    output mipsPkg::extSelE extSel,
    output logic            bSel,  // 1 selects the extended immediate
    output mipsPkg::aluOpE  aluOp,
    output logic            memWe
);

    always_comb begin
        npcSel = mipsPkg::npcSeq;  // all-inactive, acts as nop
        wrSel  = mipsPkg::wrRt;
        wdSel  = mipsPkg::wdAlu;
        regWe  = 1'b0;
        extSel = mipsPkg::extZero;
        bSel   = 1'b0;
        aluOp  = mipsPkg::aluAdd;
        memWe  = 1'b0;

        case (mipsPkg::opcodeE'(instr[31:26]))
            mipsPkg::opSpecial: begin
                case (mipsPkg::functE'(instr[5:0]))
                    mipsPkg::fnAddu: begin
                        regWe = 1'b1;
                        wrSel = mipsPkg::wrRd;
                        aluOp = mipsPkg::aluAdd;
                    end
                    mipsPkg::fnSubu: begin
                        regWe = 1'b1;
                        wrSel = mipsPkg::wrRd;
                        aluOp = mipsPkg::aluSub;
                    end
                    mipsPkg::fnJr: begin
                        npcSel = mipsPkg::npcReg;
                    end
                    default: ;  // zero word lands here too
                endcase
            end
            mipsPkg::opOri: begin
                regWe = 1'b1;
                bSel  = 1'b1;
                aluOp = mipsPkg::aluOr;
            end
            mipsPkg::opLw: begin
                regWe  = 1'b1;
                bSel   = 1'b1;
                extSel = mipsPkg::extSign;
                wdSel  = mipsPkg::wdMem;
            end
            mipsPkg::opSw: begin
                bSel   = 1'b1;
                extSel = mipsPkg::extSign;
                memWe  = 1'b1;
            end
            mipsPkg::opBeq: begin
                extSel = mipsPkg::extSign;  // offset feeds the pc adder
                npcSel = mipsPkg::npcBranch;
            end
            mipsPkg::opLui: begin
                regWe = 1'b1;
                bSel  = 1'b1;
                aluOp = mipsPkg::aluLui;
            end
            mipsPkg::opJal: begin
                regWe  = 1'b1;
                wrSel  = mipsPkg::wr31;
                wdSel  = mipsPkg::wdPcPlus4;
                npcSel = mipsPkg::npcJump;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/pcUnit.sv
`timescale 1ns/100ps

module pcUnit (
    input  logic            clk,
    input  logic            rstN,
    input  mipsPkg::npcSelE npcSel,
    input  logic            eq,
    input  logic [31:0]     extImm,
    input  logic [25:0]     target,
    input  logic [31:0]     rsData,
    output logic [31:0]     pc,
    output logic [31:0]     pcPlus4
);

    logic [31:0] npc;

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (npcSel)
            mipsPkg::npcSeq: begin
                npc = pcPlus4;
            end
            mipsPkg::npcBranch: begin
                npc = eq ? pcPlus4 + {extImm[29:0], 2'b00} : pcPlus4;
            end
            mipsPkg::npcJump: begin
                npc = {pcPlus4[31:28], target, 2'b00};  // region of the next word
            end
            mipsPkg::npcReg: begin
                npc = rsData;
            end
            default: begin
                npc = pcPlus4;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= npc;
        end
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic [4:0]     rs,
    input  logic [4:0]     rt,
    input  logic [4:0]     rd,
    input  mipsPkg::wrSelE wrSel,
    input  logic           we,
    input  logic [31:0]    wdata,
    output logic [31:0]    rsData,
    output logic [31:0]    rtData,
    output logic [4:0]     waddr
);

    logic [31:0] regs [32];

    always_comb begin
        case (wrSel)
            mipsPkg::wrRd: waddr = rd;
            mipsPkg::wr31: waddr = mipsPkg::linkReg;
            default:       waddr = rt;
        endcase
    end

    // r0 is never stored, the read mux pins it to zero
    assign rsData = (rs == 5'd0) ? 32'd0 : regs[rs];
    assign rtData = (rt == 5'd0) ? 32'd0 : regs[rt];

    always_ff @(posedge clk) begin
        if (rstN && we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: logic/execUnit.sv
`timescale 1ns/100ps

module execUnit (
    input  logic [31:0]     rsData,
    input  logic [31:0]     rtData,
    input  logic [15:0]     imm16,
    input  mipsPkg::extSelE extSel,
    input  logic            bSel,
    input  mipsPkg::aluOpE  aluOp,
    output logic [31:0]     aluRes,
    output logic [31:0]     extImm,
    output logic            eq
);

    logic [31:0] opB;

    always_comb begin
        if (extSel == mipsPkg::extSign) begin
            extImm = {{16{imm16[15]}}, imm16};
        end else begin
            extImm = {16'h0000, imm16};
        end
    end

    assign opB = bSel ? extImm : rtData;

    // beq compares the two register reads
    assign eq = (rsData == rtData);

    always_comb begin
        case (aluOp)
            mipsPkg::aluAdd: begin
                aluRes = rsData + opB;  // wraps mod 2^32
            end
            mipsPkg::aluSub: begin
                aluRes = rsData - opB;
            end
            mipsPkg::aluOr: begin
                aluRes = rsData | opB;
            end
            mipsPkg::aluLui: begin
                aluRes = {opB[15:0], 16'h0000};
            end
            default: begin
                aluRes = rsData + opB;
            end
        endcase
    end

endmodule

// File: logic/dataMem.sv
`timescale 1ns/100ps

module dataMem #(
    parameter int dmemWords = 256
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);

    localparam int idxW = $clog2(dmemWords);

    logic [31:0]     mem [dmemWords];
    logic [idxW-1:0] wordIdx;

    // byte address to word index, wrapped to the depth
    assign wordIdx = idxW'(addr[31:2] % 30'(dmemWords));

    assign rdata = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (rstN && we) begin
            mem[wordIdx] <= wdata;
        end
    end

endmodule

// File: logic/instrMem.sv
`timescale 1ns/100ps

module instrMem #(
    parameter int imemWords = 256
) (
    input  logic        clk,
    input  logic        loadWe,
    input  logic [31:0] loadAddr,  // byte address, same wrap as pc
    input  logic [31:0] loadData,
    input  logic [31:0] pc,
    output logic [31:0] instr
);

    localparam int idxW = $clog2(imemWords);

    logic [31:0]     rom [imemWords];
    logic [idxW-1:0] loadIdx;
    logic [idxW-1:0] fetchIdx;

    assign loadIdx  = idxW'(loadAddr[31:2] % 30'(imemWords));
    assign fetchIdx = idxW'(pc[31:2] % 30'(imemWords));

    assign instr = rom[fetchIdx];

    always_ff @(posedge clk) begin
        if (loadWe) begin
            rom[loadIdx] <= loadData;
        end
    end

endmodule

// File: logic/mipsCore.sv
`timescale 1ns/100ps

module mipsCore #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        imemWe,
    input  logic [31:0] imemAddr,
    input  logic [31:0] imemData,
    output logic [31:0] pc,
    output logic [31:0] instr,
    output logic        regWe,
    output logic [4:0]  regWaddr,
    output logic [31:0] regWdata,
    output logic        dmWe,
    output logic [31:0] dmAddr,
    output logic [31:0] dmWdata
);

    mipsPkg::npcSelE npcSel;
    mipsPkg::wrSelE  wrSel;
    mipsPkg::wdSelE  wdSel;
    mipsPkg::extSelE extSel;
    mipsPkg::aluOpE  aluOp;
    logic            rfWe;
    logic            bSel;
    logic            memWe;
    logic [31:0]     pcPlus4;
    logic [31:0]     rsData;
    logic [31:0]     rtData;
    logic [31:0]     extImm;
    logic [31:0]     aluRes;
    logic [31:0]     rdData;
    logic            eq;

    instrMem #(.imemWords(imemWords)) i_instrMem (
        .clk(clk), .loadWe(imemWe), .loadAddr(imemAddr), .loadData(imemData),
        .pc(pc), .instr(instr)
    );

    controller i_controller (
        .instr(instr), .npcSel(npcSel), .wrSel(wrSel), .wdSel(wdSel), .regWe(rfWe),
        .extSel(extSel), .bSel(bSel), .aluOp(aluOp), .memWe(memWe)
    );

    pcUnit i_pcUnit (
        .clk(clk), .rstN(rstN), .npcSel(npcSel), .eq(eq), .extImm(extImm),
        .target(instr[25:0]), .rsData(rsData), .pc(pc), .pcPlus4(pcPlus4)
    );

    regFile i_regFile (
        .clk(clk), .rstN(rstN), .rs(instr[25:21]), .rt(instr[20:16]),
        .rd(instr[15:11]), .wrSel(wrSel), .we(rfWe), .wdata(regWdata),
        .rsData(rsData), .rtData(rtData), .waddr(regWaddr)
    );

    execUnit i_execUnit (
        .rsData(rsData), .rtData(rtData), .imm16(instr[15:0]), .extSel(extSel),
        .bSel(bSel), .aluOp(aluOp), .aluRes(aluRes), .extImm(extImm), .eq(eq)
    );

    dataMem #(.dmemWords(dmemWords)) i_dataMem (
        .clk(clk), .rstN(rstN), .we(memWe), .addr(aluRes), .wdata(rtData),
        .rdata(rdData)
    );

    always_comb begin
        case (wdSel)
            mipsPkg::wdMem:     regWdata = rdData;
            mipsPkg::wdPcPlus4: regWdata = pcPlus4;  // jal link value
            default:            regWdata = aluRes;
        endcase
    end

    // strobes stay quiet while reset holds the core
    assign regWe   = rfWe & rstN;
    assign dmWe    = memWe & rstN;
    assign dmAddr  = aluRes;
    assign dmWdata = rtData;

endmodule

// File: verif/clkGen.sv
`timescale 1ns/100ps

module clkGen #(
    parameter real periodNs = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(periodNs / 2.0) clk = ~clk;

endmodule

// File: verif/mipsCore_chk.sv
`timescale 1ns/100ps

module mipsCore_chk (
    input logic            clk,
    input logic            rstN,
    input logic [31:0]     pc,
    input logic            regWe,
    input logic            dmWe,
    input mipsPkg::npcSelE npcSel
);

    int failCount = 0;  // read by the testbench at the end

    pcAligned: assert property (@(posedge clk) !$isunknown(pc) |-> pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned");
            failCount++;
        end

    quietInReset: assert property (@(posedge clk) !rstN |-> !regWe && !dmWe)
        else begin
            $error("write strobe high while reset is held");
            failCount++;
        end

    // sequential step moves pc by one word
    seqStep: assert property (@(posedge clk)
        rstN && npcSel == mipsPkg::npcSeq |=> pc == $past(pc) + 32'd4)
        else begin
            $error("pc did not advance by 4 after a sequential step");
            failCount++;
        end

endmodule

bind mipsCore mipsCore_chk i_chk (
    .clk(clk), .rstN(rstN), .pc(pc), .regWe(regWe), .dmWe(dmWe), .npcSel(npcSel)
);

// File: verif/mipsTb.sv
`timescale 1ns/100ps

module mipsTb;

    localparam int imemWords = 256;
    localparam int dmemWords = 256;

    typedef struct packed {
        logic [31:0] instr;
        logic        regWe;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        dmWe;
        logic [31:0] dmAddr;
        logic [31:0] dmWdata;
        logic [31:0] nextPc;
    } expT;

    logic clk, rstN, imemWe;
    logic [31:0] imemAddr, imemData, pc, instr, regWdata, dmAddr, dmWdata;
    logic regWe, dmWe;
    logic [4:0] regWaddr;

    logic [31:0] imemModel [imemWords];
    logic [31:0] dmemModel [dmemWords];
    logic [31:0] regModel [32];
    logic [31:0] pcModel = 32'd0;
    logic        inReset = 1'b0;  // previous negedge was in reset
    logic [31:0] lfsr = 32'h4e39_f1af;
    int          errCount = 0;
    int          testsFailed = 0;
    logic [31:0] prog [$];

    clkGen #(.periodNs(100.0)) i_clkGen (.clk(clk));

    mipsCore #(.imemWords(imemWords), .dmemWords(dmemWords)) i_dut (
        .clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
        .pc(pc), .instr(instr), .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata),
        .dmWe(dmWe), .dmAddr(dmAddr), .dmWdata(dmWdata)
    );

    function automatic logic [31:0] encR(int rs, int rt, int rd, logic [5:0] fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function logic [31:0] takeBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // upper bits wrap the address back onto data words 0..15
    function logic [15:0] wrappedOffset();
        return {6'(takeBits(6)), 4'h0, 4'(takeBits(4)), 2'b00};
    endfunction

    // ISA rules applied to the model state
    function automatic expT refModel(logic [31:0] curPc);
        logic [31:0] ins, pc4, a, b, se;
        expT e;
        ins = imemModel[(curPc >> 2) % imemWords];
        pc4 = curPc + 32'd4;
        a = regModel[ins[25:21]];
        b = regModel[ins[20:16]];
        se = {{16{ins[15]}}, ins[15:0]};
        e = '0;
        e.instr = ins;
        e.nextPc = pc4;
        e.waddr = ins[20:16];
        case (ins[31:26])
            6'h00: begin
                e.waddr = ins[15:11];
                if (ins[5:0] == 6'h21) begin
                    e.regWe = 1'b1;
                    e.wdata = a + b;
                end else if (ins[5:0] == 6'h23) begin
                    e.regWe = 1'b1;
                    e.wdata = a - b;
                end else if (ins[5:0] == 6'h08) begin
                    e.nextPc = a;
                end
            end
            6'h0d: begin
                e.regWe = 1'b1;
                e.wdata = a | {16'h0, ins[15:0]};
            end
            6'h23: begin
                e.regWe = 1'b1;
                e.wdata = dmemModel[((a + se) >> 2) % dmemWords];
            end
            6'h2b: begin
                e.dmWe = 1'b1;
                e.dmAddr = a + se;
                e.dmWdata = b;
            end
            6'h04: e.nextPc = (a == b) ? pc4 + (se << 2) : pc4;
            6'h0f: begin
                e.regWe = 1'b1;
                e.wdata = {ins[15:0], 16'h0};
            end
            6'h03: begin
                e.regWe = 1'b1;
                e.waddr = 5'd31;
                e.wdata = pc4;
                e.nextPc = {pc4[31:28], ins[25:0], 2'b00};
            end
            default: ;  // unknown opcode acts as nop
        endcase
        return e;
    endfunction

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("MISMATCH %s got %h expected %h at pc %h", name, got, exp, pcModel);
        errCount++;
    endtask

    always @(negedge clk) begin
        expT e;
        if (!rstN) begin
            assert (regWe === 1'b0 && dmWe === 1'b0) else begin
                $display("write strobe active while reset is held");
                errCount++;
            end
            if (inReset) begin
                assert (pc === 32'd0) else mismatch("pc", pc, 32'd0);
            end
            inReset = 1'b1;
            pcModel = 32'd0;
        end else begin
            inReset = 1'b0;
            e = refModel(pcModel);
            assert (pc === pcModel) else mismatch("pc", pc, pcModel);
            assert (instr === e.instr) else mismatch("instr", instr, e.instr);
            assert (regWe === e.regWe) else mismatch("regWe", 32'(regWe), 32'(e.regWe));
            assert (dmWe === e.dmWe) else mismatch("dmWe", 32'(dmWe), 32'(e.dmWe));
            if (e.regWe) begin
                assert (regWaddr === e.waddr)
                    else mismatch("regWaddr", 32'(regWaddr), 32'(e.waddr));
                assert (regWdata === e.wdata) else mismatch("regWdata", regWdata, e.wdata);
                if (e.waddr != 5'd0) regModel[e.waddr] = e.wdata;
            end
            if (e.dmWe) begin
                assert (dmAddr === e.dmAddr) else mismatch("dmAddr", dmAddr, e.dmAddr);
                assert (dmWdata === e.dmWdata) else mismatch("dmWdata", dmWdata, e.dmWdata);
                dmemModel[(e.dmAddr >> 2) % dmemWords] = e.dmWdata;
            end
            pcModel = e.nextPc;
        end
    end

    task automatic stepCycle();
        @(posedge clk);
        #10;
    endtask

    // hold reset and write every imem word, unused ones as unique unknown opcodes
    task automatic loadProgram();
        logic [31:0] w;
        rstN = 1'b0;
        repeat (4) stepCycle();
        for (int i = 0; i < imemWords; i++) begin
            w = (i < prog.size()) ? prog[i] : {6'h3f, 26'(i) ^ 26'h2a5_5a5a};
            imemModel[i] = w;
            imemWe = 1'b1;
            imemAddr = 32'(i) << 2;
            imemData = w;
            stepCycle();
        end
        imemWe = 1'b0;
        rstN = 1'b1;
    endtask

    task automatic runUntil(logic [31:0] endPc, int limit);
        int n;
        n = 0;
        while (pc !== endPc && n < limit) begin
            stepCycle();
            n++;
        end
        if (pc !== endPc) begin
            $display("timeout: pc never reached %h", endPc);
            $display("Something failed");
            $finish;
        end
    endtask

    task automatic finishTest(string name, int errsBefore);
        if (errCount != errsBefore) testsFailed++;
        $display("test %s done, %0d errors", name, errCount - errsBefore);
    endtask

    initial begin
        int errs;
        logic [31:0] kind;
        rstN = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        foreach (regModel[i]) regModel[i] = '0;

        errs = errCount;
        prog = '{encI(6'h0d, 0, 1, 16'h0005)};
        loadProgram();
        runUntil(32'd4, 20);
        finishTest("reset", errs);

        errs = errCount;
        prog = '{encI(6'h0d, 0, 1, 16'h1234), encI(6'h0f, 0, 2, 16'hffff),
                 encI(6'h0d, 2, 2, 16'hfffe), encR(2, 1, 3, 6'h21), encR(1, 2, 4, 6'h23),
                 encR(1, 1, 0, 6'h21), encR(0, 0, 5, 6'h21)};
        loadProgram();
        runUntil(32'd28, 40);
        finishTest("arith", errs);

        errs = errCount;
        prog = '{encI(6'h0d, 0, 1, 16'h0040), encI(6'h0d, 0, 2, 16'hbeef),
                 encI(6'h0f, 0, 3, 16'h1234), encI(6'h2b, 1, 2, 16'h0008),
                 encI(6'h2b, 1, 3, 16'hfffc), encI(6'h23, 1, 4, 16'h0008),
                 encI(6'h23, 1, 5, 16'hfffc), encR(4, 5, 6, 6'h21)};
        loadProgram();
        runUntil(32'd32, 40);
        finishTest("memory", errs);

        errs = errCount;
        prog = '{encI(6'h0d, 0, 1, 16'd7), encI(6'h0d, 0, 2, 16'd7), encI(6'h04, 1, 2, 16'd2),
                 encI(6'h0d, 0, 3, 16'd1), encI(6'h0d, 0, 3, 16'd2), encI(6'h04, 1, 0, 16'd1),
                 encI(6'h0d, 0, 5, 16'd3), encI(6'h0d, 0, 6, 16'd1), encR(5, 6, 5, 6'h23),
                 encI(6'h04, 5, 0, 16'd1), encI(6'h04, 0, 0, 16'hfffd)};
        loadProgram();
        runUntil(32'd44, 60);
        finishTest("branch", errs);

        errs = errCount;
        prog = '{encI(6'h0d, 0, 1, 16'd9), {6'h03, 26'd4}, encI(6'h0d, 0, 2, 16'd1),
                 encI(6'h04, 0, 0, 16'd2), encR(1, 1, 3, 6'h21), encR(31, 0, 0, 6'h08),
                 32'hfc00_0123};
        loadProgram();
        runUntil(32'd28, 40);
        finishTest("jal", errs);

        // prologue sets r31, r1..r7 and data words 0..15, then a random mix
        errs = errCount;
        prog = '{{6'h03, 26'd1}};
        for (int r = 1; r < 8; r++) prog.push_back(encI(6'h0d, 0, r, 16'(takeBits(16))));
        for (int k = 0; k < 16; k++) prog.push_back(encI(6'h2b, 0, 0, 16'(k * 4)));
        while (prog.size() < imemWords) begin
            kind = takeBits(4) % 10;
            case (kind)
                0: prog.push_back(encR(takeBits(3), takeBits(3), takeBits(3), 6'h21));
                1: prog.push_back(encR(takeBits(3), takeBits(3), takeBits(3), 6'h23));
                2: prog.push_back(encI(6'h0d, takeBits(3), takeBits(3), 16'(takeBits(16))));
                3: prog.push_back(encI(6'h23, 0, takeBits(3), wrappedOffset()));
                4: prog.push_back(encI(6'h2b, 0, takeBits(3), wrappedOffset()));
                5: prog.push_back(encI(6'h04, takeBits(3), takeBits(3),
                                       16'(takeBits(4)) - 16'd8));
                6: prog.push_back(encI(6'h0f, 0, takeBits(3), 16'(takeBits(16))));
                7: prog.push_back({6'h03, 26'(takeBits(8))});
                8: prog.push_back(encR(31, 0, 0, 6'h08));
                default: prog.push_back(takeBits(1) ? 32'h0 : {6'h3e, 26'(takeBits(26))});
            endcase
        end
        loadProgram();
        repeat (400) stepCycle();
        finishTest("random", errs);

        $display("tests 6, failed %0d, errors %0d, assertion failures %0d",
                 testsFailed, errCount, i_dut.i_chk.failCount);
        if (errCount == 0 && i_dut.i_chk.failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/mipsPkg.sv
logic/controller.sv
logic/pcUnit.sv
logic/regFile.sv
logic/execUnit.sv
logic/dataMem.sv
logic/instrMem.sv
logic/mipsCore.sv
verif/clkGen.sv
verif/mipsCore_chk.sv
verif/mipsTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= mipsTb
RTLTOP    ?= mipsCore
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTLTOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
